/* all.f */
hdl/pifo_pkg.sv
hdl/slot_min_select.sv
hdl/node_update.sv
hdl/level_ram.sv
hdl/pifo_level.sv
hdl/pifo_tree.sv
dv/tb_pifo.sv

/* dv/pifo_trace.txt */
# op prio meta ready (op 0 idle, 1 push, 2 pop; prio and meta in hex)
# pop lines hold the expected element, ready is o_ready before the line
# empty pop after reset
2 ffff 00 1
0 0000 00 0
# four pushes then four pops
1 0040 a1 1
1 0010 a2 1
1 0030 a3 1
1 0020 a4 1
2 0010 a2 1
2 0020 a4 0
2 0030 a3 0
2 0040 a1 0
0 0000 00 0
# twelve descending pushes spill below the root
1 00c0 01 1
1 00b0 02 1
1 00a0 03 1
1 0090 04 1
1 0080 05 1
1 0070 06 1
1 0060 07 1
1 0050 08 1
1 0040 09 1
1 0030 0a 1
1 0020 0b 1
1 0010 0c 1
2 0010 0c 1
2 0020 0b 0
2 0030 0a 0
2 0040 09 0
2 0050 08 0
2 0060 07 0
2 0070 06 0
2 0080 05 0
2 0090 04 0
2 00a0 03 0
2 00b0 02 0
2 00c0 01 0
# interleaved pushes and pops
0 0000 00 0
1 0500 11 1
1 0300 12 1
2 0300 12 1
1 0100 13 0
2 0100 13 1
0 0000 00 0
1 0200 14 1
1 0400 15 1
2 0200 14 1
2 0400 15 0
1 0050 16 0
2 0050 16 1
2 0500 11 0
2 ffff 00 0
0 0000 00 0

/* dv/tb_pifo.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_pifo;

    localparam int         LEVELS      = 3;
    localparam int         WAIT_CYCLES = 20;     // Timeout of each wait loop
    localparam logic [1:0] OP_IDLE     = 2'd0;
    localparam logic [1:0] OP_PUSH     = 2'd1;
    localparam logic [1:0] OP_POP      = 2'd2;

    logic            clk = 1'b0;
    logic            arst_n;
    logic            push;
    logic            pop;
    pifo_pkg::elem_t push_elem;
    logic            ready;
    logic            pop_valid;
    pifo_pkg::elem_t pop_elem;

    int value_errors = 0;
    int run_errors   = 0;   // Timeouts and trace problems

    pifo_tree #(
        .LEVELS (LEVELS)
    ) u_dut (
        .i_clk       (clk),
        .i_arst_n    (arst_n),
        .i_push      (push),
        .i_pop       (pop),
        .i_push_elem (push_elem),
        .o_ready     (ready),
        .o_pop_valid (pop_valid),
        .o_pop_elem  (pop_elem)
    );

    always #5 clk = ~clk;

    // --------------------
    // Compare tasks
    // --------------------
    task automatic check_elem(input string name, input pifo_pkg::elem_t exp,
                              input pifo_pkg::elem_t act);
        if (act !== exp) begin
            value_errors++;
            $display("** Error [%s] pop element: expected prio %h meta %h, got prio %h meta %h",
                     name, exp.prio, exp.meta, act.prio, act.meta);
        end
    endtask

    task automatic check_ready(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            value_errors++;
            $display("** Error [%s] o_ready: expected %b, got %b", name, exp, act);
        end
    endtask

    task automatic check_pop_valid(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            value_errors++;
            $display("** Error [%s] o_pop_valid: expected %b, got %b", name, exp, act);
        end
    endtask

    // --------------------
    // Waits
    // --------------------
    task automatic wait_ready(output bit ok);
        int n;
        n = 0;
        while (ready !== 1'b1 && n < WAIT_CYCLES) begin
            @(posedge clk);
            #1;
            n++;
        end
        ok = (ready === 1'b1);
        if (!ok) begin
            run_errors++;
            $display("Timeout: o_ready stayed low for %0d cycles", WAIT_CYCLES);
        end else if (n > 1) begin
            run_errors++;
            $display("o_ready stayed low for %0d cycles instead of one", n);
        end
    endtask

    task automatic wait_pop_valid(output bit ok);
        int n;
        n = 0;
        while (pop_valid !== 1'b1 && n < WAIT_CYCLES) begin
            @(posedge clk);
            #1;
            n++;
        end
        ok = (pop_valid === 1'b1);
        if (!ok) begin
            run_errors++;
            $display("Timeout: o_pop_valid never came after a pop");
        end
    endtask

    // One trace line, entered and left 1 ns after a rising edge
    task automatic apply_step(input string name, input logic [1:0] op,
                              input pifo_pkg::elem_t elem, input logic exp_rdy,
                              output bit ok);
        ok = 1'b1;
        check_ready(name, exp_rdy, ready);
        if (op != OP_IDLE) begin
            wait_ready(ok);
            if (ok) begin
                check_pop_valid(name, 1'b0, pop_valid);   // Pop result lasts one cycle
            end
        end
        if (ok) begin
            push      = (op == OP_PUSH);
            pop       = (op == OP_POP);
            push_elem = (op == OP_PUSH) ? elem : pifo_pkg::EMPTY_ELEM;
            @(posedge clk);
            #1;
            push = 1'b0;
            pop  = 1'b0;
            check_pop_valid(name, op == OP_POP, pop_valid);
            if (op == OP_POP) begin
                wait_pop_valid(ok);
                if (ok) begin
                    check_elem(name, elem, pop_elem);   // Expected value from the trace
                end
            end
        end
    endtask

    initial begin
        int              fd;
        int              line_no;
        int              fields;
        string           line;
        string           test_name;
        logic [31:0]     f_op;
        logic [31:0]     f_prio;
        logic [31:0]     f_meta;
        logic [31:0]     f_rdy;
        pifo_pkg::elem_t exp_elem;
        bit              ok;
        bit              abort;

        push      = 1'b0;
        pop       = 1'b0;
        push_elem = pifo_pkg::EMPTY_ELEM;
        arst_n    = 1'b0;
        test_name = "setup";
        line_no   = 0;
        abort     = 1'b0;

        repeat (3) @(posedge clk);
        #1;
        arst_n = 1'b1;

        fd = $fopen("dv/pifo_trace.txt", "r");
        if (fd == 0) begin
            run_errors++;
            $display("Could not open dv/pifo_trace.txt");
            abort = 1'b1;
        end

        while (!abort && !$feof(fd)) begin
            if ($fgets(line, fd) == 0) begin
                break;
            end
            line_no++;
            if (line.len() < 2) begin
                continue;
            end
            // Comment lines name the test that follows
            if (line.getc(0) == "#") begin
                test_name = line.substr(2, line.len() - 2);
                continue;
            end
            fields = $sscanf(line, "%h %h %h %h", f_op, f_prio, f_meta, f_rdy);
            if (fields != 4) begin
                run_errors++;
                $display("Trace line %0d could not be parsed", line_no);
                continue;
            end
            exp_elem = '{prio: pifo_pkg::prio_t'(f_prio), meta: pifo_pkg::meta_t'(f_meta)};
            apply_step($sformatf("%s, line %0d", test_name, line_no), f_op[1:0],
                       exp_elem, f_rdy[0], ok);
            abort = !ok;
        end

        if (fd != 0) begin
            $fclose(fd);
        end
        repeat (2) @(posedge clk);

        $display("Summary: %0d value errors, %0d run errors", value_errors, run_errors);
        if (value_errors == 0 && run_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* hdl/level_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module level_ram #(
    parameter int DEPTH = 1
) (
    input  wire                  i_clk,
    input  wire                  i_arst_n,
    input  wire                  i_rd_en,
    input  pifo_pkg::node_addr_t i_rd_addr,
    output pifo_pkg::node_t      o_rd_node,
    input  wire                  i_wr_en,
    input  pifo_pkg::node_addr_t i_wr_addr,
    input  pifo_pkg::node_t      i_wr_node
);

    localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    pifo_pkg::node_t  mem [DEPTH];
    logic [IDX_W-1:0] rd_idx;
    logic [IDX_W-1:0] wr_idx;

    assign rd_idx = i_rd_addr[IDX_W-1:0];
    assign wr_idx = i_wr_addr[IDX_W-1:0];

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= pifo_pkg::EMPTY_NODE;   // Every tree starts empty
            end
            o_rd_node <= pifo_pkg::EMPTY_NODE;
        end else begin
            if (i_wr_en) begin
                mem[wr_idx] <= i_wr_node;
            end
            // Read data holds until the next read
            if (i_rd_en) begin
                if (i_wr_en && (i_wr_addr == i_rd_addr)) begin
                    o_rd_node <= i_wr_node;       // Write-first bypass
                end else begin
                    o_rd_node <= mem[rd_idx];
                end
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/node_update.sv */
`timescale 1ns/1ps
`default_nettype none

module node_update #(
    parameter bit LAST_LEVEL = 1'b0
) (
    input  pifo_pkg::level_state_e i_state,
    input  pifo_pkg::node_t        i_node,            // Registered read data
    input  pifo_pkg::elem_t        i_new_elem,        // Latched push element
    input  pifo_pkg::elem_t        i_child_pop_elem,
    output pifo_pkg::node_t        o_node,
    output logic                   o_child_push,
    output logic                   o_child_pop,
    output pifo_pkg::elem_t        o_child_elem,
    output pifo_pkg::slot_idx_t    o_child_slot,
    output pifo_pkg::elem_t        o_pop_elem
);

    pifo_pkg::slot_idx_t cnt_slot;
    pifo_pkg::slot_idx_t prio_slot;

    slot_min_select u_sel (
        .i_node          (i_node),
        .o_min_cnt_slot  (cnt_slot),
        .o_min_prio_slot (prio_slot)
    );

    // Smallest element of the node, sampled by the parent
    assign o_pop_elem = i_node[prio_slot].elem;

    always_comb begin
        o_node       = i_node;
        o_child_push = 1'b0;
        o_child_pop  = 1'b0;
        o_child_elem = i_new_elem;
        o_child_slot = cnt_slot;

        case (i_state)
            // --------------------
            // Push
            // --------------------
            pifo_pkg::ST_PUSH: begin
                o_node[cnt_slot].cnt = i_node[cnt_slot].cnt + 1'b1;
                if (i_node[cnt_slot].elem.prio == pifo_pkg::PRIO_EMPTY) begin
                    // Free slot absorbs the element, nothing goes down
                    o_node[cnt_slot].elem = i_new_elem;
                end else if (i_new_elem.prio < i_node[cnt_slot].elem.prio) begin
                    o_node[cnt_slot].elem = i_new_elem;          // Swap in
                    o_child_elem          = i_node[cnt_slot].elem;
                    o_child_push          = !LAST_LEVEL;
                end else begin
                    o_child_elem = i_new_elem;                   // New one sinks
                    o_child_push = !LAST_LEVEL;
                end
            end

            // --------------------
            // Pop and write-back
            // --------------------
            pifo_pkg::ST_POP, pifo_pkg::ST_WB: begin
                o_child_slot = prio_slot;
                o_child_pop  = !LAST_LEVEL && (i_state == pifo_pkg::ST_POP);
                // Child element is only valid in ST_WB, so upper levels
                // overwrite the ST_POP value one cycle later
                if (LAST_LEVEL) begin
                    o_node[prio_slot].elem = pifo_pkg::EMPTY_ELEM;
                end else begin
                    o_node[prio_slot].elem = i_child_pop_elem;
                end
                if (i_node[prio_slot].cnt != '0) begin
                    o_node[prio_slot].cnt = i_node[prio_slot].cnt - 1'b1;
                end
            end

            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

/* hdl/pifo_level.sv */
`timescale 1ns/1ps
`default_nettype none

module pifo_level #(
    parameter int LEVEL_IDX  = 0,
    parameter bit LAST_LEVEL = 1'b0
) (
    input  wire                  i_clk,
    input  wire                  i_arst_n,
    input  pifo_pkg::level_cmd_t i_cmd,
    output pifo_pkg::level_cmd_t o_child_cmd,
    input  pifo_pkg::elem_t      i_child_pop_elem,
    output pifo_pkg::elem_t      o_pop_elem,
    output logic                 o_pop_valid,
    output logic                 o_busy
);

    localparam int DEPTH = pifo_pkg::FANOUT ** LEVEL_IDX;  // Nodes in this level

    pifo_pkg::level_state_e state_q;
    pifo_pkg::level_state_e state_d;
    pifo_pkg::elem_t        elem_q;
    pifo_pkg::node_addr_t   addr_q;
    pifo_pkg::node_t        rd_node;
    pifo_pkg::node_t        new_node;
    pifo_pkg::elem_t        child_elem;
    pifo_pkg::slot_idx_t    child_slot;
    logic                   child_push;
    logic                   child_pop;
    logic                   accept;

    // --------------------
    // Controller
    // --------------------
    assign accept = (state_q != pifo_pkg::ST_POP) && (i_cmd.push || i_cmd.pop);

    always_comb begin
        if (state_q == pifo_pkg::ST_POP) begin
            state_d = pifo_pkg::ST_WB;     // Wait for the child's element
        end else if (i_cmd.pop) begin
            state_d = pifo_pkg::ST_POP;
        end else if (i_cmd.push) begin
            state_d = pifo_pkg::ST_PUSH;
        end else begin
            state_d = pifo_pkg::ST_IDLE;
        end
    end

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state_q <= pifo_pkg::ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            elem_q <= '0;
            addr_q <= '0;
        end else if (accept) begin
            elem_q <= i_cmd.elem;
            addr_q <= i_cmd.addr;
        end
    end

    // --------------------
    // Node memory and update
    // --------------------
    level_ram #(
        .DEPTH (DEPTH)
    ) u_ram (
        .i_clk     (i_clk),
        .i_arst_n  (i_arst_n),
        .i_rd_en   (accept),
        .i_rd_addr (i_cmd.addr),
        .o_rd_node (rd_node),
        .i_wr_en   (state_q != pifo_pkg::ST_IDLE),
        .i_wr_addr (addr_q),
        .i_wr_node (new_node)
    );

    node_update #(
        .LAST_LEVEL (LAST_LEVEL)
    ) u_update (
        .i_state          (state_q),
        .i_node           (rd_node),
        .i_new_elem       (elem_q),
        .i_child_pop_elem (i_child_pop_elem),
        .o_node           (new_node),
        .o_child_push     (child_push),
        .o_child_pop      (child_pop),
        .o_child_elem     (child_elem),
        .o_child_slot     (child_slot),
        .o_pop_elem       (o_pop_elem)
    );

    // Child node sits at parent * 4 + slot
    assign o_child_cmd = '{
        push: child_push,
        pop:  child_pop,
        elem: child_elem,
        addr: {addr_q[pifo_pkg::NODE_ADDR_W-3:0], child_slot}
    };

    assign o_pop_valid = (state_q == pifo_pkg::ST_POP);
    assign o_busy      = (state_q == pifo_pkg::ST_POP);  // Root back-pressure

endmodule

`default_nettype wire

/* hdl/pifo_pkg.sv */
`default_nettype none

package pifo_pkg;

    // --------------------
    // Widths
    // --------------------
    localparam int PRIO_W      = 16;  // Lower value leaves first
    localparam int META_W      = 8;
    localparam int CNT_W       = 10;  // Elements in a slot and its subtree
    localparam int FANOUT      = 4;   // Tied to the two-bit slot index
    localparam int NODE_ADDR_W = 8;   // Enough for five levels

    typedef logic [PRIO_W-1:0]      prio_t;
    typedef logic [META_W-1:0]      meta_t;
    typedef logic [CNT_W-1:0]       cnt_t;
    typedef logic [NODE_ADDR_W-1:0] node_addr_t;
    typedef logic [1:0]             slot_idx_t;

    // --------------------
    // Node contents
    // --------------------
    typedef struct packed {
        prio_t prio;
        meta_t meta;
    } elem_t;

    typedef struct packed {
        cnt_t  cnt;
        elem_t elem;
    } slot_t;

    typedef slot_t [FANOUT-1:0] node_t;

    // All-ones priority marks an empty slot
    localparam prio_t PRIO_EMPTY = '1;
    localparam elem_t EMPTY_ELEM = '{prio: PRIO_EMPTY, meta: '0};
    localparam slot_t EMPTY_SLOT = '{cnt: '0, elem: EMPTY_ELEM};
    localparam node_t EMPTY_NODE = {FANOUT{EMPTY_SLOT}};

    // Command from one level to the next
    typedef struct packed {
        logic       push;
        logic       pop;
        elem_t      elem;
        node_addr_t addr;
    } level_cmd_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_PUSH,
        ST_POP,
        ST_WB
    } level_state_e;

endpackage

`default_nettype wire

/* hdl/pifo_tree.sv */
`timescale 1ns/1ps
`default_nettype none

module pifo_tree #(
    parameter int LEVELS = 3   // 2 to 5
) (
    input  wire             i_clk,
    input  wire             i_arst_n,
    input  wire             i_push,
    input  wire             i_pop,
    input  pifo_pkg::elem_t i_push_elem,
    output logic            o_ready,
    output logic            o_pop_valid,
    output pifo_pkg::elem_t o_pop_elem
);

    pifo_pkg::level_cmd_t cmd       [LEVELS];
    pifo_pkg::elem_t      pop_elem  [LEVELS];
    logic                 pop_valid [LEVELS];
    logic                 busy      [LEVELS];

    // Root command always targets node zero
    assign cmd[0] = '{push: i_push, pop: i_pop, elem: i_push_elem, addr: '0};

    // --------------------
    // Level chain
    // --------------------
    for (genvar k = 0; k < LEVELS; k++) begin : g_level
        if (k < LEVELS - 1) begin : g_inner
            pifo_level #(
                .LEVEL_IDX  (k),
                .LAST_LEVEL (1'b0)
            ) u_level (
                .i_clk            (i_clk),
                .i_arst_n         (i_arst_n),
                .i_cmd            (cmd[k]),
                .o_child_cmd      (cmd[k+1]),
                .i_child_pop_elem (pop_elem[k+1]),
                .o_pop_elem       (pop_elem[k]),
                .o_pop_valid      (pop_valid[k]),
                .o_busy           (busy[k])
            );
        end else begin : g_last
            pifo_level #(
                .LEVEL_IDX  (k),
                .LAST_LEVEL (1'b1)
            ) u_level (
                .i_clk            (i_clk),
                .i_arst_n         (i_arst_n),
                .i_cmd            (cmd[k]),
                .o_child_cmd      (),
                .i_child_pop_elem (pifo_pkg::EMPTY_ELEM),   // No level below
                .o_pop_elem       (pop_elem[k]),
                .o_pop_valid      (pop_valid[k]),
                .o_busy           (busy[k])
            );
        end
    end

    assign o_ready     = !busy[0];      // Low only while the root pops
    assign o_pop_valid = pop_valid[0];
    assign o_pop_elem  = pop_elem[0];

endmodule

`default_nettype wire

/* hdl/slot_min_select.sv */
`timescale 1ns/1ps
`default_nettype none

module slot_min_select (
    input  pifo_pkg::node_t     i_node,
    output pifo_pkg::slot_idx_t o_min_cnt_slot,   // Push target
    output pifo_pkg::slot_idx_t o_min_prio_slot   // Pop source
);

    // Linear scan over the slots
    // Strict compares, so on a tie the lower slot wins
    always_comb begin
        pifo_pkg::cnt_t  min_cnt;
        pifo_pkg::prio_t min_prio;

        min_cnt         = i_node[0].cnt;
        min_prio        = i_node[0].elem.prio;
        o_min_cnt_slot  = '0;
        o_min_prio_slot = '0;

        for (int i = 1; i < pifo_pkg::FANOUT; i++) begin
            if (i_node[i].cnt < min_cnt) begin
                min_cnt        = i_node[i].cnt;
                o_min_cnt_slot = pifo_pkg::slot_idx_t'(i);
            end
            if (i_node[i].elem.prio < min_prio) begin
                min_prio        = i_node[i].elem.prio;
                o_min_prio_slot = pifo_pkg::slot_idx_t'(i);
            end
        end
    end

endmodule

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
set -eo pipefail

cd "$(dirname "$0")"

verilator --binary --timing -f all.f --top-module tb_pifo -o tb_pifo
./obj_dir/tb_pifo | tee sim.log

if grep -qF '** FAIL **' sim.log; then
    echo "Simulation reported errors, see sim.log"
    exit 1
fi
echo "Simulation finished without errors"
